// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = lc4_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+dv
logic/lc4_pkg.sv
logic/lc4_fetch.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_execute.sv
logic/lc4_pipeline.sv
dv/lc4_tb.sv

// File: dv/lc4_tb_model.svh
`ifndef LC4_TB_MODEL_SVH
`define LC4_TB_MODEL_SVH

// Architectural state seen by the reference model
logic [15:0] ref_regs [8];
logic [2:0]  ref_nzp;     // N, Z, P of the last committed result
logic [15:0] ref_pc;      // Next instruction expected to retire
logic [31:0] lfsr_state;

// One expected retirement
typedef struct packed {
  logic [15:0] pc;
  logic [15:0] insn;
  logic        regfile_we;
  logic [2:0]  wsel;
  logic [15:0] data;
  logic        nzp_we;
  logic [2:0]  nzp_bits;
  logic [15:0] next_pc;
  logic        taken;      // Branch redirected the fetch stream
} retire_t;

function automatic void model_reset(input logic [15:0] start_pc);
  for (int i = 0; i < 8; i++) begin
    ref_regs[i] = 16'h0000;  // Registers clear on reset
  end
  ref_nzp = 3'b000;  // No condition true until a result commits
  ref_pc  = start_pc;
endfunction

// Sign and zero rule of a 16-bit result
function automatic logic [2:0] sign_code(input logic [15:0] value);
  logic [2:0] code;
  if (value[15]) begin
    code = 3'b100;
  end else if (value == 16'h0000) begin
    code = 3'b010;
  end else begin
    code = 3'b001;
  end
  return code;
endfunction

// Execute one instruction on the architectural state
function automatic retire_t model_step(input logic [15:0] pc, input logic [15:0] insn);
  retire_t     r;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] imm5;
  logic [15:0] imm9;
  r         = '0;
  r.pc      = pc;
  r.insn    = insn;
  r.wsel    = insn[11:9];
  r.next_pc = pc + 16'd1;
  a    = ref_regs[insn[8:6]];
  b    = ref_regs[insn[2:0]];
  imm5 = {{11{insn[4]}}, insn[4:0]};
  imm9 = {{7{insn[8]}}, insn[8:0]};
  case (insn[15:12])
    4'b0001: begin  // Arithmetic
      r.regfile_we = 1'b1;
      if (insn[5]) begin
        r.data = a + imm5;
      end else if (insn[4:3] == 2'b00) begin
        r.data = a + b;
      end else if (insn[4:3] == 2'b10) begin
        r.data = a - b;
      end else begin
        r.regfile_we = 1'b0;  // MUL and DIV retire as NOP
      end
    end
    4'b0101: begin  // Logic
      r.regfile_we = 1'b1;
      if (insn[5]) begin
        r.data = a & imm5;
      end else begin
        case (insn[4:3])
          2'b00:   r.data = a & b;
          2'b01:   r.data = ~a;
          2'b10:   r.data = a | b;
          default: r.data = a ^ b;
        endcase
      end
    end
    4'b1001: begin  // CONST
      r.regfile_we = 1'b1;
      r.data       = imm9;
    end
    4'b0000: begin  // BR, empty mask never matches
      if ((insn[11:9] & ref_nzp) != 3'b000) begin
        r.taken   = 1'b1;
        r.next_pc = pc + 16'd1 + imm9;
      end
    end
    default: ;  // Anything else is a NOP
  endcase
  r.nzp_we = r.regfile_we;  // Every register write also sets NZP
  if (r.regfile_we) begin
    r.nzp_bits       = sign_code(r.data);
    ref_regs[r.wsel] = r.data;
    ref_nzp          = r.nzp_bits;
  end
  return r;
endfunction

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic lfsr_bit();
  logic fb;
  fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] value;
  value = 16'h0000;
  for (int i = 0; i < n; i++) begin
    value = {value[14:0], lfsr_bit()};
  end
  return value;
endfunction

`endif

// File: dv/lc4_tb.sv
`timescale 1ns/1ps

module lc4_tb;

  import lc4_pkg::*;

  localparam logic [15:0] reset_pc  = 16'h8200;
  localparam int          rom_depth = 512;
  localparam int          rand_len  = 200;
  localparam int          reset_gap = 4;  // Bubbles between reset and first retirement

  logic        gwe;
  logic        i_rst;
  logic [15:0] i_insn;
  logic [15:0] o_pc;
  logic [1:0]  o_test_stall;
  logic [15:0] o_test_pc;
  logic [15:0] o_test_insn;
  logic        o_test_regfile_we;
  logic [2:0]  o_test_regfile_wsel;
  logic [15:0] o_test_regfile_data;
  logic        o_test_nzp_we;
  logic [2:0]  o_test_nzp_new_bits;

  logic [15:0] rom [rom_depth];  // Instruction memory, word 0 at reset_pc
  int          prog_len;         // Write pointer while building
  int          directed_len;
  int          retired;
  int          flush_gap;        // Bubbles since the last retirement
  int          expect_gap;

  `include "lc4_tb_model.svh"

  retire_t exp_entry;

  lc4_pipeline #(
    .reset_pc (reset_pc)
  ) u_dut (
    .gwe                 (gwe),
    .i_rst               (i_rst),
    .i_insn              (i_insn),
    .o_pc                (o_pc),
    .o_test_stall        (o_test_stall),
    .o_test_pc           (o_test_pc),
    .o_test_insn         (o_test_insn),
    .o_test_regfile_we   (o_test_regfile_we),
    .o_test_regfile_wsel (o_test_regfile_wsel),
    .o_test_regfile_data (o_test_regfile_data),
    .o_test_nzp_we       (o_test_nzp_we),
    .o_test_nzp_new_bits (o_test_nzp_new_bits)
  );

  always #4 gwe = ~gwe;  // 8 ns period

  // Instruction encoders, LC4 field layout
  function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [1:0] sub,
                                          input logic [2:0] rt);
    return {op, rd, rs, 1'b0, sub, rt};
  endfunction

  function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [4:0] imm);
    return {op, rd, rs, 1'b1, imm};
  endfunction

  function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] value);
    return {op_const, rd, value};
  endfunction

  function automatic logic [15:0] enc_br(input logic [2:0] mask, input logic [8:0] off);
    return {op_br, mask, off};
  endfunction

  function automatic logic [15:0] rom_word(input logic [15:0] addr);
    logic [15:0] idx;
    idx = addr - reset_pc;
    if ($isunknown(addr) || int'(idx) >= rom_depth) begin
      return 16'h0000;  // Outside the ROM reads as NOP
    end
    return rom[idx[8:0]];
  endfunction

  task automatic emit(input logic [15:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] cls;
    for (int i = 0; i < rom_depth; i++) begin
      rom[i] = enc_br(3'b000, 9'(i));  // NOP fill, offset field carries the index
    end
    prog_len = 0;
    // Dependent ALU chain at distances one to three
    emit(enc_const(3'd1, 9'd5));
    emit(enc_const(3'd2, -9'd3));
    emit(enc_rrr(op_add, 3'd3, 3'd1, sub_add, 3'd2));    // R3 = 2
    emit(enc_rrr(op_add, 3'd4, 3'd3, sub_sub, 3'd1));    // R4 = -3
    emit(enc_imm(op_add, 3'd5, 3'd4, 5'd7));             // R5 = 4
    emit(enc_rrr(op_logic, 3'd6, 3'd5, sub_and, 3'd3));
    emit(enc_rrr(op_logic, 3'd7, 3'd6, sub_not, 3'd0));
    emit(enc_rrr(op_logic, 3'd1, 3'd7, sub_or, 3'd5));
    emit(enc_rrr(op_logic, 3'd2, 3'd1, sub_xor, 3'd1));  // Zero result
    emit(enc_imm(op_logic, 3'd3, 3'd1, -5'd2));
    // Branches on in-flight NZP
    emit(enc_const(3'd4, 9'd0));
    emit(enc_br(3'b100, 9'd2));                          // Not taken, Z in memory
    emit(enc_br(3'b000, 9'd0));                          // NOP
    emit(enc_imm(op_add, 3'd4, 3'd4, -5'd1));            // R4 = -1
    emit(enc_br(3'b010, 9'd3));                          // Not taken
    emit(enc_br(3'b100, 9'd2));                          // Taken, N from writeback
    emit(enc_const(3'd5, 9'h0aa));                       // Squashed
    emit(enc_const(3'd6, 9'h055));                       // Squashed
    emit(enc_rrr(op_add, 3'd7, 3'd4, sub_add, 3'd4));    // R7 = -2
    emit(enc_br(3'b111, 9'd1));                          // Always taken
    emit(enc_const(3'd7, 9'd1));                         // Squashed
    emit(enc_rrr(op_add, 3'd0, 3'd7, sub_sub, 3'd7));    // R7 from the register file
    emit(enc_br(3'b011, 9'd0));                          // Taken onto its own fall-through
    emit(enc_imm(op_add, 3'd1, 3'd0, -5'd16));
    emit(enc_br(3'b101, 9'd1));
    emit(enc_const(3'd1, 9'd3));                         // Squashed
    emit(enc_br(3'b000, 9'd0));
    directed_len = prog_len;
    // Random ALU, CONST and forward branch mix
    for (int k = 0; k < rand_len; k++) begin
      rd  = 3'(rand_bits(3));
      rs  = 3'(rand_bits(3));
      rt  = 3'(rand_bits(3));
      cls = 3'(rand_bits(3));
      case (cls)
        3'd0, 3'd1: emit(enc_rrr(op_add, rd, rs, (rand_bits(1) != 0) ? sub_sub : sub_add, rt));
        3'd2:       emit(enc_imm(op_add, rd, rs, 5'(rand_bits(5))));
        3'd3:       emit(enc_rrr(op_logic, rd, rs, 2'(rand_bits(2)), rt));
        3'd4:       emit(enc_imm(op_logic, rd, rs, 5'(rand_bits(5))));
        3'd5:       emit(enc_const(rd, 9'(rand_bits(9))));
        default:    emit(enc_br(3'(rand_bits(3)), 9'(rand_bits(2))));  // Skip 0 to 3
      endcase
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp)
      else stop_run($sformatf("MISMATCH %s %s expected %h actual %h", test, field, exp, act));
  endtask

  // Compare one writeback trace entry against the model
  task automatic check_trace();
    string test;
    if (o_test_stall == stall_flush) begin
      assert (!o_test_regfile_we && !o_test_nzp_we)
        else stop_run("A flush bubble in the trace has a write enable set");
      flush_gap++;
    end else begin
      exp_entry = model_step(ref_pc, rom_word(ref_pc));
      test = (int'(exp_entry.pc - reset_pc) < directed_len) ? "directed" : "random";
      check_value(test, "stall", 16'(stall_none), 16'(o_test_stall));
      check_value(test, "flush gap", 16'(expect_gap), 16'(flush_gap));
      check_value(test, "pc", exp_entry.pc, o_test_pc);
      check_value(test, "insn", exp_entry.insn, o_test_insn);
      check_value(test, "regfile_we", 16'(exp_entry.regfile_we), 16'(o_test_regfile_we));
      check_value(test, "nzp_we", 16'(exp_entry.nzp_we), 16'(o_test_nzp_we));
      if (exp_entry.regfile_we) begin
        check_value(test, "wsel", 16'(exp_entry.wsel), 16'(o_test_regfile_wsel));
        check_value(test, "data", exp_entry.data, o_test_regfile_data);
      end
      if (exp_entry.nzp_we) begin
        check_value(test, "nzp", 16'(exp_entry.nzp_bits), 16'(o_test_nzp_new_bits));
      end
      ref_pc     = exp_entry.next_pc;
      expect_gap = exp_entry.taken ? 2 : 0;  // Fetch and decode slots die on a taken branch
      flush_gap  = 0;
      retired++;
    end
  endtask

  always @(posedge gwe) begin
    if (!i_rst) begin
      check_trace();
    end
  end

  // Wait until the model has retired past a ROM offset
  task automatic wait_past(input int offset, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (int'(ref_pc - reset_pc) < offset && cycles < limit) begin
      @(negedge gwe);
      cycles++;
    end
    if (int'(ref_pc - reset_pc) < offset) begin
      stop_run($sformatf("Timeout: the %s did not retire within %0d cycles", what, limit));
    end
  endtask

  initial begin
    gwe        = 1'b0;
    i_rst      = 1'b1;
    i_insn     = 16'h0000;
    lfsr_state = 32'h7308_cb04;
    retired    = 0;
    flush_gap  = 0;
    expect_gap = reset_gap;
    model_reset(reset_pc);
    build_program();
    repeat (10) @(posedge gwe);
    @(negedge gwe);
    i_rst = 1'b0;
    check_value("reset", "o_pc", reset_pc, o_pc);  // Fetch starts at the reset address
    wait_past(directed_len, 200, "directed program");
    wait_past(prog_len, 1000, "random program");
    $display("Retired %0d instructions", retired);
    $display("Simulation passed");
    $finish;
  end

  // ROM answers for the PC of the coming edge
  always @(negedge gwe) begin
    i_insn <= rom_word(o_pc);
  end

endmodule

// File: logic/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
  input  lc4_pkg::lc4_insn_t               i_insn,
  input  logic                             i_valid,       // Low for bubbles and squashed slots
  output logic [lc4_pkg::reg_sel_w-1:0]    o_rs_sel,
  output logic [lc4_pkg::reg_sel_w-1:0]    o_rt_sel,
  output logic [lc4_pkg::reg_sel_w-1:0]    o_wsel,
  output logic                             o_rs_re,
  output logic                             o_rt_re,
  output logic                             o_regfile_we,
  output logic                             o_nzp_we,
  output logic                             o_is_branch,
  output logic                             o_is_const
);

  import lc4_pkg::*;

  logic is_add_ok;  // ADD, SUB or ADD imm5
  logic is_alu;     // Any supported ALU op
  logic is_not;     // NOT reads rs only

  assign is_add_ok = (i_insn.r.opcode == op_add) &&
                     (i_insn.r.imm || (i_insn.r.sub == sub_add) || (i_insn.r.sub == sub_sub));
  assign is_alu    = is_add_ok || (i_insn.r.opcode == op_logic);
  assign is_not    = (i_insn.r.opcode == op_logic) && !i_insn.r.imm &&
                     (i_insn.r.sub == sub_not);

  // Selects come straight from the fields, enables say whether they matter
  assign o_rs_sel = i_insn.r.rs;
  assign o_rt_sel = i_insn.r.rt;
  assign o_wsel   = i_insn.r.rd;  // Same bits as b.nzp for CONST

  always_comb begin
    o_rs_re      = 1'b0;
    o_rt_re      = 1'b0;
    o_regfile_we = 1'b0;
    o_nzp_we     = 1'b0;
    o_is_branch  = 1'b0;
    o_is_const   = 1'b0;
    if (i_valid) begin
      if (is_alu) begin
        o_rs_re      = 1'b1;
        o_rt_re      = !i_insn.r.imm && !is_not;  // Immediate forms carry imm5 in rt
        o_regfile_we = 1'b1;
        o_nzp_we     = 1'b1;
      end else if (i_insn.b.opcode == op_const) begin
        o_regfile_we = 1'b1;
        o_nzp_we     = 1'b1;
        o_is_const   = 1'b1;
      end else if (i_insn.b.opcode == op_br) begin
        o_is_branch  = (i_insn.b.nzp != '0);  // Empty mask is the NOP
      end
      // MUL, DIV and every other opcode fall through as NOP
    end
  end

  // Branches never write a register
  always_comb begin
    if (i_insn.b.opcode == op_br) begin
      assert (!o_regfile_we) else $error("decoder: branch with register write");
    end
  end

endmodule

// File: logic/lc4_execute.sv
`timescale 1ns/1ps

module lc4_execute (
  input  lc4_pkg::lc4_insn_t            i_insn,
  input  logic [lc4_pkg::word_w-1:0]    i_pc,
  input  logic                          i_valid,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_rs_sel,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_rt_sel,
  input  logic [lc4_pkg::word_w-1:0]    i_rs_data,    // Read in decode
  input  logic [lc4_pkg::word_w-1:0]    i_rt_data,
  input  logic                          i_is_branch,
  input  logic                          i_is_const,
  // Memory stage, one ahead
  input  logic [lc4_pkg::word_w-1:0]    i_m_result,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_m_wsel,
  input  logic                          i_m_we,
  input  logic [lc4_pkg::nzp_w-1:0]     i_m_nzp,
  input  logic                          i_m_nzp_we,
  // Writeback stage, two ahead
  input  logic [lc4_pkg::word_w-1:0]    i_w_result,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_w_wsel,
  input  logic                          i_w_we,
  input  logic [lc4_pkg::nzp_w-1:0]     i_w_nzp,
  input  logic                          i_w_nzp_we,
  input  logic [lc4_pkg::nzp_w-1:0]     i_cur_nzp,    // Committed NZP register
  output logic [lc4_pkg::word_w-1:0]    o_result,
  output logic [lc4_pkg::nzp_w-1:0]     o_nzp,
  output logic                          o_flush,
  output logic [lc4_pkg::word_w-1:0]    o_target
);

  import lc4_pkg::*;

  logic [word_w-1:0] rs_val;   // Operands after bypass
  logic [word_w-1:0] rt_val;
  logic [word_w-1:0] imm5;     // Sign-extended insn[4:0]
  logic [word_w-1:0] imm9;     // Sign-extended insn[8:0]
  logic [word_w-1:0] alu;
  logic [nzp_w-1:0]  br_nzp;   // Newest condition codes
  logic              taken;

  // Operand bypass, youngest producer first
  assign rs_val = (i_m_we && (i_m_wsel == i_rs_sel)) ? i_m_result :
                  (i_w_we && (i_w_wsel == i_rs_sel)) ? i_w_result : i_rs_data;
  assign rt_val = (i_m_we && (i_m_wsel == i_rt_sel)) ? i_m_result :
                  (i_w_we && (i_w_wsel == i_rt_sel)) ? i_w_result : i_rt_data;

  assign imm5 = {{(word_w - 5){i_insn.r.sub[1]}}, i_insn.r.sub, i_insn.r.rt};
  assign imm9 = {{(word_w - 9){i_insn.b.off[8]}}, i_insn.b.off};

  always_comb begin
    alu = '0;  // Branches and NOPs
    case (i_insn.r.opcode)
      op_add: begin
        if (i_insn.r.imm) begin
          alu = rs_val + imm5;
        end else if (i_insn.r.sub == sub_sub) begin
          alu = rs_val - rt_val;
        end else if (i_insn.r.sub == sub_add) begin
          alu = rs_val + rt_val;
        end
      end
      op_logic: begin
        if (i_insn.r.imm) begin
          alu = rs_val & imm5;
        end else begin
          case (i_insn.r.sub)
            sub_and: alu = rs_val & rt_val;
            sub_not: alu = ~rs_val;
            sub_or:  alu = rs_val | rt_val;
            sub_xor: alu = rs_val ^ rt_val;
            default: alu = '0;
          endcase
        end
      end
      default: alu = '0;
    endcase
  end

  assign o_result = i_is_const ? imm9 : alu;  // CONST skips the ALU

  // Sign and zero of the result
  assign o_nzp[2] = $signed(o_result) < 0;
  assign o_nzp[1] = o_result == '0;
  assign o_nzp[0] = $signed(o_result) > 0;

  // Branch sees in-flight NZP before the committed copy
  assign br_nzp = i_m_nzp_we ? i_m_nzp :
                  i_w_nzp_we ? i_w_nzp : i_cur_nzp;

  assign taken    = (i_insn.b.nzp & br_nzp) != '0;
  assign o_flush  = i_valid && i_is_branch && taken;
  assign o_target = i_pc + 1'b1 + imm9;  // PC-relative to the next word

  // Condition a branch resolves against has at most one of N, Z, P
  always_comb begin
    if (i_valid && i_is_branch) begin
      assert ($onehot0(br_nzp)) else $error("execute: branch NZP not one-hot %b", br_nzp);
    end
  end

endmodule

// File: logic/lc4_fetch.sv
`timescale 1ns/1ps

module lc4_fetch #(
  parameter logic [lc4_pkg::word_w-1:0] reset_pc = 16'h8200
) (
  input  logic                       gwe,
  input  logic                       i_rst,
  input  logic [lc4_pkg::word_w-1:0] i_insn,     // Word at o_pc, same cycle
  input  logic                       i_flush,    // Taken branch in execute
  input  logic [lc4_pkg::word_w-1:0] i_target,   // Branch destination
  output logic [lc4_pkg::word_w-1:0] o_pc,
  output logic [lc4_pkg::word_w-1:0] o_d_pc,
  output lc4_pkg::lc4_insn_t         o_d_insn,
  output logic                       o_d_valid
);

  import lc4_pkg::*;

  logic [word_w-1:0] pc;
  logic [word_w-1:0] next_pc;

  assign next_pc = i_flush ? i_target : pc + 1'b1;  // Redirect wins over sequential
  assign o_pc    = pc;

  // PC register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // Fetch to decode register
  always_ff @(posedge gwe) begin
    o_d_pc <= pc;
    if (i_rst || i_flush) begin
      o_d_insn  <= '0;    // Zero word is a BR with empty mask
      o_d_valid <= 1'b0;  // Bubble
    end else begin
      o_d_insn  <= i_insn;
      o_d_valid <= 1'b1;
    end
  end

endmodule

// File: logic/lc4_pipeline.sv
`timescale 1ns/1ps

module lc4_pipeline #(
  parameter logic [lc4_pkg::word_w-1:0] reset_pc = 16'h8200
) (
  input  logic                          gwe,
  input  logic                          i_rst,
  input  logic [lc4_pkg::word_w-1:0]    i_insn,               // Instruction at o_pc
  output logic [lc4_pkg::word_w-1:0]    o_pc,
  // Writeback trace
  output logic [1:0]                    o_test_stall,
  output logic [lc4_pkg::word_w-1:0]    o_test_pc,
  output logic [lc4_pkg::word_w-1:0]    o_test_insn,
  output logic                          o_test_regfile_we,
  output logic [lc4_pkg::reg_sel_w-1:0] o_test_regfile_wsel,
  output logic [lc4_pkg::word_w-1:0]    o_test_regfile_data,
  output logic                          o_test_nzp_we,
  output logic [lc4_pkg::nzp_w-1:0]     o_test_nzp_new_bits
);

  import lc4_pkg::*;

  // Decode
  logic [word_w-1:0]    d_pc;
  lc4_insn_t            d_insn;
  logic                 d_valid;
  logic                 d_live;      // Valid and not squashed by a branch
  logic [reg_sel_w-1:0] d_rs_sel, d_rt_sel, d_wsel;
  logic                 d_rs_re, d_rt_re;
  logic                 d_regfile_we, d_nzp_we, d_is_branch, d_is_const;
  logic [word_w-1:0]    d_rs_data, d_rt_data;

  // Execute
  logic [word_w-1:0]    x_pc;
  lc4_insn_t            x_insn;
  logic                 x_valid;
  logic [reg_sel_w-1:0] x_rs_sel, x_rt_sel, x_wsel;
  logic                 x_regfile_we, x_nzp_we, x_is_branch, x_is_const;
  logic [word_w-1:0]    x_rs_data, x_rt_data;
  logic [word_w-1:0]    x_result;
  logic [nzp_w-1:0]     x_nzp;
  logic                 x_flush;
  logic [word_w-1:0]    x_target;

  // Memory, no data access in this subset
  logic [word_w-1:0]    m_pc, m_insn, m_result;
  logic                 m_valid, m_regfile_we, m_nzp_we;
  logic [reg_sel_w-1:0] m_wsel;
  logic [nzp_w-1:0]     m_nzp;

  // Writeback
  logic [word_w-1:0]    w_pc, w_insn, w_result;
  logic                 w_valid, w_regfile_we, w_nzp_we;
  logic [reg_sel_w-1:0] w_wsel;
  logic [nzp_w-1:0]     w_nzp;

  logic [nzp_w-1:0]     cur_nzp;     // Committed condition codes

  lc4_fetch #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_insn    (i_insn),
    .i_flush   (x_flush),
    .i_target  (x_target),
    .o_pc      (o_pc),
    .o_d_pc    (d_pc),
    .o_d_insn  (d_insn),
    .o_d_valid (d_valid)
  );

  assign d_live = d_valid && !x_flush;  // Decode slot dies with a taken branch

  lc4_decoder u_decoder (
    .i_insn       (d_insn),
    .i_valid      (d_live),
    .o_rs_sel     (d_rs_sel),
    .o_rt_sel     (d_rt_sel),
    .o_wsel       (d_wsel),
    .o_rs_re      (d_rs_re),
    .o_rt_re      (d_rt_re),
    .o_regfile_we (d_regfile_we),
    .o_nzp_we     (d_nzp_we),
    .o_is_branch  (d_is_branch),
    .o_is_const   (d_is_const)
  );

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_rs_sel  (d_rs_sel),
    .i_rt_sel  (d_rt_sel),
    .i_wsel    (w_wsel),
    .i_wdata   (w_result),
    .i_we      (w_regfile_we),
    .o_rs_data (d_rs_data),
    .o_rt_data (d_rt_data)
  );

  // Decode to execute
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      x_valid      <= 1'b0;
      x_regfile_we <= 1'b0;
      x_nzp_we     <= 1'b0;
      x_is_branch  <= 1'b0;
      x_is_const   <= 1'b0;
    end else begin
      x_valid      <= d_live;
      x_regfile_we <= d_regfile_we;  // Already low for a squashed slot
      x_nzp_we     <= d_nzp_we;
      x_is_branch  <= d_is_branch;
      x_is_const   <= d_is_const;
    end
    x_pc     <= d_pc;
    x_insn   <= d_insn;
    x_rs_sel <= d_rs_sel;
    x_rt_sel <= d_rt_sel;
    x_wsel   <= d_wsel;
    if (d_rs_re) begin
      x_rs_data <= d_rs_data;  // Operand held when not read
    end
    if (d_rt_re) begin
      x_rt_data <= d_rt_data;
    end
  end

  lc4_execute u_execute (
    .i_insn      (x_insn),
    .i_pc        (x_pc),
    .i_valid     (x_valid),
    .i_rs_sel    (x_rs_sel),
    .i_rt_sel    (x_rt_sel),
    .i_rs_data   (x_rs_data),
    .i_rt_data   (x_rt_data),
    .i_is_branch (x_is_branch),
    .i_is_const  (x_is_const),
    .i_m_result  (m_result),
    .i_m_wsel    (m_wsel),
    .i_m_we      (m_regfile_we),
    .i_m_nzp     (m_nzp),
    .i_m_nzp_we  (m_nzp_we),
    .i_w_result  (w_result),
    .i_w_wsel    (w_wsel),
    .i_w_we      (w_regfile_we),
    .i_w_nzp     (w_nzp),
    .i_w_nzp_we  (w_nzp_we),
    .i_cur_nzp   (cur_nzp),
    .o_result    (x_result),
    .o_nzp       (x_nzp),
    .o_flush     (x_flush),
    .o_target    (x_target)
  );

  // Execute to memory, then memory to writeback
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      m_valid      <= 1'b0;
      m_regfile_we <= 1'b0;
      m_nzp_we     <= 1'b0;
      w_valid      <= 1'b0;
      w_regfile_we <= 1'b0;
      w_nzp_we     <= 1'b0;
    end else begin
      m_valid      <= x_valid;
      m_regfile_we <= x_regfile_we;
      m_nzp_we     <= x_nzp_we;
      w_valid      <= m_valid;
      w_regfile_we <= m_regfile_we;
      w_nzp_we     <= m_nzp_we;
    end
    m_pc     <= x_pc;
    m_insn   <= x_insn;
    m_wsel   <= x_wsel;
    m_result <= x_result;
    m_nzp    <= x_nzp;
    w_pc     <= m_pc;
    w_insn   <= m_insn;
    w_wsel   <= m_wsel;
    w_result <= m_result;
    w_nzp    <= m_nzp;
  end

  // NZP register, committed at writeback
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      cur_nzp <= '0;  // No branch taken until a result commits
    end else if (w_nzp_we) begin
      cur_nzp <= w_nzp;
    end
  end

  // Trace taps on writeback
  assign o_test_stall        = w_valid ? stall_none : stall_flush;
  assign o_test_pc           = w_pc;
  assign o_test_insn         = w_insn;
  assign o_test_regfile_we   = w_regfile_we;
  assign o_test_regfile_wsel = w_wsel;
  assign o_test_regfile_data = w_result;
  assign o_test_nzp_we       = w_nzp_we;
  assign o_test_nzp_new_bits = w_nzp;

  // Taken branch squashes both younger slots, fetch and decode
  assert property (@(posedge gwe) disable iff (i_rst) x_flush |=> (!x_valid && !d_valid))
    else $error("pipeline: flush left a live instruction behind the branch");

endmodule

// File: logic/lc4_pkg.sv
package lc4_pkg;

  // Datapath widths
  localparam int word_w    = 16;  // Data and address
  localparam int reg_sel_w = 3;   // Eight registers
  localparam int nzp_w     = 3;   // N, Z, P

  // Opcodes in insn[15:12]
  localparam logic [3:0] op_br    = 4'b0000;
  localparam logic [3:0] op_add   = 4'b0001;  // ADD, SUB, ADD imm5
  localparam logic [3:0] op_logic = 4'b0101;  // AND, NOT, OR, XOR, AND imm5
  localparam logic [3:0] op_const = 4'b1001;

  // Arithmetic sub-opcodes in insn[4:3], only with insn[5] clear
  localparam logic [1:0] sub_add = 2'b00;
  localparam logic [1:0] sub_sub = 2'b10;  // 01 and 11 would be MUL and DIV

  // Logic sub-opcodes in insn[4:3], only with insn[5] clear
  localparam logic [1:0] sub_and = 2'b00;
  localparam logic [1:0] sub_not = 2'b01;
  localparam logic [1:0] sub_or  = 2'b10;
  localparam logic [1:0] sub_xor = 2'b11;

  // Trace stall codes
  localparam logic [1:0] stall_none  = 2'd0;
  localparam logic [1:0] stall_flush = 2'd2;  // Reset bubbles show the same code

  // One instruction word, two ways to read it
  typedef union packed {
    // Register and immediate format
    struct packed {
      logic [3:0]           opcode;
      logic [reg_sel_w-1:0] rd;
      logic [reg_sel_w-1:0] rs;
      logic                 imm;  // Set for the imm5 forms
      logic [1:0]           sub;  // Top of imm5 when imm is set
      logic [reg_sel_w-1:0] rt;   // Bottom of imm5 when imm is set
    } r;
    // Branch and CONST format
    struct packed {
      logic [3:0]       opcode;
      logic [nzp_w-1:0] nzp;  // BR mask, rd for CONST
      logic [8:0]       off;  // Signed offset or constant
    } b;
  } lc4_insn_t;

endpackage

// File: logic/lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
  input  logic                          gwe,
  input  logic                          i_rst,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_rs_sel,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_rt_sel,
  input  logic [lc4_pkg::reg_sel_w-1:0] i_wsel,    // From writeback
  input  logic [lc4_pkg::word_w-1:0]    i_wdata,
  input  logic                          i_we,
  output logic [lc4_pkg::word_w-1:0]    o_rs_data,
  output logic [lc4_pkg::word_w-1:0]    o_rt_data
);

  import lc4_pkg::*;

  localparam int num_regs = 2 ** reg_sel_w;

  logic [word_w-1:0] regs [num_regs];

  logic rs_hit;  // Writeback targets the rs read
  logic rt_hit;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // Writeback to decode bypass
  // Decode sees the value being written this cycle
  assign rs_hit = i_we && (i_wsel == i_rs_sel);
  assign rt_hit = i_we && (i_wsel == i_rt_sel);

  assign o_rs_data = rs_hit ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = rt_hit ? i_wdata : regs[i_rt_sel];

endmodule
